// File: list.f
mmu_pkg.sv
pte_pkg.sv
pte_fetch_if.sv
walk_step_if.sv
pte_decode.sv
walk_engine.sv
walk_result.sv
ptw_top.sv
ptw_assertions.sv
tb_ptw.sv

// File: tb_ptw.sv
`timescale 1ns/1ps

module tb_ptw;

    localparam int NUM_WALKS   = 200;
    localparam int WALK_CYCLES = 24;
    localparam int CLK_PERIOD  = 100;
    localparam int WAIT_LIMIT  = 100;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic [mmu_pkg::MEM_ADDR_W-1:0] avl_address;
    logic                           avl_read;
    logic [pte_pkg::PTE_W-1:0]      avl_readdata;
    logic                           avl_readdatavalid;
    logic                           avl_waitrequest;
    logic [pte_pkg::RESP_W-1:0]     avl_response;
    logic                           resolve_request;
    logic                           resolve_ack;
    logic [mmu_pkg::VPN_W-1:0]      virtual_address;
    logic [mmu_pkg::PPN_W-1:0]      matp_ppn;
    logic                           resolve_done;
    logic                           resolve_pagefault;
    logic                           resolve_accessfault;
    logic [pte_pkg::FLAGS_W-1:0]    resolve_access_bits;
    logic [mmu_pkg::PPN_W-1:0]      resolve_physical_address;

    integer seed           = 32'h59c3;
    int     assert_errors  = 0;
    int     timeout_errors = 0;

    // missing entries of the page table read as zero
    logic [pte_pkg::PTE_W-1:0] mem [logic [mmu_pkg::MEM_ADDR_W-1:0]];
    bit                        poison [logic [mmu_pkg::MEM_ADDR_W-1:0]];

    logic [mmu_pkg::MEM_ADDR_W-1:0] req_addr   = '0;
    logic                           read_taken = 1'b0;
    logic                           data_taken = 1'b0;
    logic                           next_wait  = 1'b0;
    int                             next_delay = 0;
    int                             pend_delay = 0;
    bit                             pending    = 1'b0;

    ptw_top u_dut (.*);

    bind ptw_top ptw_assertions u_checks (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // port is stable mid-cycle so the next cycle is decided here
    always @(negedge clk) begin
        read_taken = avl_read && !avl_waitrequest;
        data_taken = avl_readdatavalid && !avl_waitrequest;
        if (read_taken) begin
            req_addr = avl_address;
        end
        next_wait  = ({$random(seed)} % 3) == 0;
        next_delay = {$random(seed)} % 4;
    end

    task automatic present_entry(input logic [mmu_pkg::MEM_ADDR_W-1:0] addr);
        avl_readdatavalid = 1'b1;
        avl_readdata      = mem.exists(addr) ? mem[addr] : '0;
        avl_response      = poison.exists(addr) ? 2'b10 : 2'b00;
    endtask

    // memory returns data 1 to 4 cycles after the read is taken
    always @(posedge clk) begin
        #1;
        avl_waitrequest = next_wait;
        if (data_taken) begin
            avl_readdatavalid = 1'b0;
            avl_response      = '0;
        end
        if (read_taken) begin
            pending    = 1'b1;
            pend_delay = next_delay;
        end
        if (pending) begin
            if (pend_delay == 0) begin
                present_entry(req_addr);
                pending = 1'b0;
            end else begin
                pend_delay = pend_delay - 1;
            end
        end
    end

    function automatic logic [31:0] leaf_entry(input logic [9:0] ppn_lo);
        logic [31:0] e;
        e = $random(seed);
        e[19:10] = ppn_lo;
        e[pte_pkg::V_BIT] = 1'b1;
        if (!e[pte_pkg::X_BIT]) begin
            e[pte_pkg::R_BIT] = 1'b1;
        end
        if (!e[pte_pkg::R_BIT]) begin
            e[pte_pkg::W_BIT] = 1'b0;
        end
        return e;
    endfunction

    function automatic logic [31:0] pointer_entry(input logic [21:0] next);
        logic [31:0] e;
        e = $random(seed);
        e[31:10] = next;
        e[3:0] = 4'b0001;
        return e;
    endfunction

    // invalid or write-only entry
    function automatic logic [31:0] faulty_entry();
        logic [31:0] e;
        e = $random(seed);
        if (e[30]) begin
            e[pte_pkg::V_BIT] = 1'b0;
        end else begin
            e[3:0] = 4'b0101;
        end
        return e;
    endfunction

    task automatic run_walk(input int kind, input int num);
        logic [mmu_pkg::VPN_W-1:0]      vpn;
        logic [mmu_pkg::PPN_W-1:0]      root;
        logic [mmu_pkg::PPN_W-1:0]      next;
        logic [mmu_pkg::MEM_ADDR_W-1:0] l1_addr;
        logic [mmu_pkg::MEM_ADDR_W-1:0] l0_addr;
        logic [31:0]                    rnd;
        int                             cycles;
        @(posedge clk);
        #1;
        rnd  = $random(seed);
        vpn  = rnd[mmu_pkg::VPN_W-1:0];
        rnd  = $random(seed);
        root = rnd[mmu_pkg::PPN_W-1:0];
        rnd  = $random(seed);
        next = rnd[mmu_pkg::PPN_W-1:0];
        if (next == root) begin
            next = ~root;
        end
        l1_addr = {root, vpn[19:10], 2'b00};
        l0_addr = {next, vpn[9:0], 2'b00};
        mem.delete();
        poison.delete();
        rnd = $random(seed);
        // level 1 is a pointer for kinds 4 and up
        if (kind >= 4) begin
            mem[l1_addr] = pointer_entry(next);
        end
        case (kind)
            0: begin
                mem[l1_addr]    = leaf_entry(10'd0);
                poison[l1_addr] = 1'b1;
            end
            1: mem[l1_addr] = faulty_entry();
            2: mem[l1_addr] = leaf_entry(rnd[9:0] | 10'd1);
            3: mem[l1_addr] = leaf_entry(10'd0);
            4: mem[l0_addr] = leaf_entry(rnd[9:0]);
            5: mem[l0_addr] = pointer_entry(rnd[21:0]);
            6: begin
                mem[l0_addr]    = leaf_entry(rnd[9:0]);
                poison[l0_addr] = 1'b1;
            end
            7: mem[l0_addr] = faulty_entry();
            // level-0 entry left out so it reads as zero
            default: begin
            end
        endcase
        virtual_address = vpn;
        matp_ppn        = root;
        resolve_request = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!resolve_ack && cycles < WAIT_LIMIT);
        @(posedge clk);
        #1;
        resolve_request = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!resolve_done && cycles < WAIT_LIMIT);
        if (!resolve_done) begin
            $display("walk %0d of kind %0d got no done within %0d cycles at %0t",
                     num, kind, WAIT_LIMIT, $time);
            timeout_errors++;
        end
    endtask

    initial begin
        rst_n             = 1'b0;
        avl_readdata      = '0;
        avl_readdatavalid = 1'b0;
        avl_waitrequest   = 1'b0;
        avl_response      = '0;
        resolve_request   = 1'b0;
        virtual_address   = '0;
        matp_ppn          = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // every kind once and then a random mix
        for (int n = 0; n < NUM_WALKS; n++) begin
            run_walk((n < 9) ? n : ({$random(seed)} % 9), n);
        end
        repeat (2) @(posedge clk);
        $display("assertion errors: %0d, walk timeouts: %0d", assert_errors, timeout_errors);
        if (assert_errors == 0 && timeout_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_WALKS * WALK_CYCLES * CLK_PERIOD);
        $display("timeout: the walks did not finish within %0d ns", $time);
        $display("assertion errors: %0d, walk timeouts: %0d", assert_errors, timeout_errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: ptw_assertions.sv
`timescale 1ns/1ps

module ptw_assertions (
    input logic                           clk,
    input logic                           rst_n,
    input logic [mmu_pkg::MEM_ADDR_W-1:0] avl_address,
    input logic                           avl_read,
    input logic [pte_pkg::PTE_W-1:0]      avl_readdata,
    input logic                           avl_readdatavalid,
    input logic                           avl_waitrequest,
    input logic [pte_pkg::RESP_W-1:0]     avl_response,
    input logic                           resolve_request,
    input logic                           resolve_ack,
    input logic [mmu_pkg::VPN_W-1:0]      virtual_address,
    input logic [mmu_pkg::PPN_W-1:0]      matp_ppn,
    input logic                           resolve_done,
    input logic                           resolve_pagefault,
    input logic                           resolve_accessfault,
    input logic [pte_pkg::FLAGS_W-1:0]    resolve_access_bits,
    input logic [mmu_pkg::PPN_W-1:0]      resolve_physical_address
);

    logic                      busy;
    logic                      walk_level;
    logic [mmu_pkg::VPN_W-1:0] walk_vpn;
    logic [1:0]                reads;
    logic                      accept;
    logic                      rsp_taken;
    logic                      rsp_bad;
    logic                      ent_leaf;
    logic                      ent_ptr;
    logic                      ent_bad;
    logic                      ent_good_leaf;
    logic                      ent_descend;
    logic [mmu_pkg::PPN_W-1:0] leaf_ppn;

    assign accept    = resolve_request && resolve_ack;
    assign rsp_taken = busy && avl_readdatavalid && !avl_waitrequest;
    assign rsp_bad   = (avl_response != '0);

    // entry classes as seen on the bus
    assign ent_leaf = avl_readdata[pte_pkg::R_BIT] || avl_readdata[pte_pkg::X_BIT];
    assign ent_ptr  = (avl_readdata[3:0] == 4'b0001);
    assign ent_bad  = !avl_readdata[pte_pkg::V_BIT] ||
                      (!avl_readdata[pte_pkg::R_BIT] && avl_readdata[pte_pkg::W_BIT]) ||
                      (ent_leaf && walk_level && avl_readdata[19:10] != '0) ||
                      (ent_ptr && !walk_level) || (!ent_leaf && !ent_ptr);
    assign ent_good_leaf = !ent_bad && ent_leaf;
    assign ent_descend   = !ent_bad && ent_ptr;

    // megapage takes the low index from the request
    assign leaf_ppn = walk_level ? {avl_readdata[31:20], walk_vpn[9:0]} : avl_readdata[31:10];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            walk_level <= 1'b1;
            walk_vpn   <= '0;
            reads      <= '0;
        end else if (!busy) begin
            if (accept) begin
                busy       <= 1'b1;
                walk_level <= 1'b1;
                walk_vpn   <= virtual_address;
                reads      <= '0;
            end
        end else begin
            if (avl_read && !avl_waitrequest) begin
                reads <= reads + 2'd1;
            end
            if (rsp_taken && !rsp_bad && ent_descend) begin
                walk_level <= 1'b0;
            end else if (rsp_taken) begin
                busy <= 1'b0;
            end
        end
    end

    access_fault_done: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_taken && rsp_bad |=> resolve_done && resolve_accessfault && !resolve_pagefault)
    else begin
        $error("error at %0t: bus error not reported as access fault", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

    page_fault_done: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_taken && !rsp_bad && ent_bad |=>
        resolve_done && resolve_pagefault && !resolve_accessfault)
    else begin
        $error("error at %0t: bad entry not reported as page fault", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

    leaf_done: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_taken && !rsp_bad && ent_good_leaf |=>
        resolve_done && !resolve_pagefault && !resolve_accessfault &&
        resolve_physical_address == $past(leaf_ppn) &&
        resolve_access_bits == $past(avl_readdata[7:0]))
    else begin
        $error("error at %0t: leaf translation wrong or faulted", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

    second_read: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_taken && !rsp_bad && ent_descend |=> !resolve_done && avl_read &&
        avl_address == {$past(avl_readdata[31:10]), walk_vpn[9:0], 2'b00})
    else begin
        $error("error at %0t: level-0 read missing or at wrong address", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

    first_read: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> avl_read &&
        avl_address == {$past(matp_ppn), $past(virtual_address[19:10]), 2'b00})
    else begin
        $error("error at %0t: level-1 read missing or at wrong address", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

    read_held: assert property (@(posedge clk) disable iff (!rst_n)
        avl_read && avl_waitrequest |=> avl_read && $stable(avl_address))
    else begin
        $error("error at %0t: read dropped or moved under waitrequest", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

    read_count: assert property (@(posedge clk) disable iff (!rst_n)
        reads <= 2'd2 && (!avl_read || busy))
    else begin
        $error("error at %0t: read outside a walk or more than two reads", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

    ack_idle: assert property (@(posedge clk) disable iff (!rst_n)
        resolve_ack == !busy)
    else begin
        $error("error at %0t: ack not matching idle", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resolve_done |=> !resolve_done)
    else begin
        $error("error at %0t: done longer than a cycle", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> !avl_read && !resolve_done && resolve_ack &&
        !resolve_pagefault && !resolve_accessfault)
    else begin
        $error("error at %0t: outputs not in reset state", $time);
        tb_ptw.assert_errors = tb_ptw.assert_errors + 1;
    end

endmodule

// File: ptw_top.sv
`timescale 1ns/1ps

module ptw_top (
    input  logic                           clk,
    input  logic                           rst_n,

    output logic [mmu_pkg::MEM_ADDR_W-1:0] avl_address,
    output logic                           avl_read,
    input  logic [pte_pkg::PTE_W-1:0]      avl_readdata,
    input  logic                           avl_readdatavalid,
    input  logic                           avl_waitrequest,
    input  logic [pte_pkg::RESP_W-1:0]     avl_response,

    input  logic                           resolve_request,
    output logic                           resolve_ack,
    input  logic [mmu_pkg::VPN_W-1:0]      virtual_address,
    input  logic [mmu_pkg::PPN_W-1:0]      matp_ppn,

    output logic                           resolve_done,
    output logic                           resolve_pagefault,
    output logic                           resolve_accessfault,
    output logic [pte_pkg::FLAGS_W-1:0]    resolve_access_bits,
    output logic [mmu_pkg::PPN_W-1:0]      resolve_physical_address
);

    logic                           level;
    logic                           walking;
    logic [mmu_pkg::VPN_PART_W-1:0] vpn_lo;

    pte_fetch_if u_fetch_if ();
    walk_step_if u_step_if ();

    // memory port onto the fetch bundle
    assign avl_address = u_fetch_if.address;
    assign avl_read    = u_fetch_if.read;

    assign u_fetch_if.readdata      = avl_readdata;
    assign u_fetch_if.readdatavalid = avl_readdatavalid;
    assign u_fetch_if.waitrequest   = avl_waitrequest;
    assign u_fetch_if.response      = avl_response;

    pte_decode u_decode (
        .fetch   (u_fetch_if.decode),
        .level   (level),
        .vpn_lo  (vpn_lo),
        .walking (walking),
        .step    (u_step_if.decode)
    );

    walk_engine u_engine (
        .clk             (clk),
        .rst_n           (rst_n),
        .resolve_request (resolve_request),
        .virtual_address (virtual_address),
        .matp_ppn        (matp_ppn),
        .resolve_ack     (resolve_ack),
        .level           (level),
        .vpn_lo          (vpn_lo),
        .walking         (walking),
        .fetch           (u_fetch_if.engine),
        .step            (u_step_if.engine)
    );

    walk_result u_result (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .step                     (u_step_if.result),
        .resolve_done             (resolve_done),
        .resolve_pagefault        (resolve_pagefault),
        .resolve_accessfault      (resolve_accessfault),
        .resolve_access_bits      (resolve_access_bits),
        .resolve_physical_address (resolve_physical_address)
    );

endmodule

// File: walk_result.sv
`timescale 1ns/1ps

module walk_result (
    input  logic                         clk,
    input  logic                         rst_n,
    walk_step_if.result                  step,
    output logic                         resolve_done,
    output logic                         resolve_pagefault,
    output logic                         resolve_accessfault,
    output logic [pte_pkg::FLAGS_W-1:0]  resolve_access_bits,
    output logic [mmu_pkg::PPN_W-1:0]    resolve_physical_address
);

    logic final_step;

    // anything but a descend finishes the walk
    assign final_step = step.step_valid && (step.step != pte_pkg::step_descend);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resolve_done        <= 1'b0;
            resolve_pagefault   <= 1'b0;
            resolve_accessfault <= 1'b0;
        end else begin
            resolve_done <= final_step;
            if (final_step) begin
                resolve_pagefault   <= (step.step == pte_pkg::step_page_fault);
                resolve_accessfault <= (step.step == pte_pkg::step_access_fault);
            end
        end
    end

    // translation held until the next done
    always_ff @(posedge clk) begin
        if (final_step) begin
            resolve_physical_address <= step.phys_ppn;
            resolve_access_bits      <= step.access_bits;
        end
    end

endmodule

// File: walk_engine.sv
`timescale 1ns/1ps

module walk_engine (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           resolve_request,
    input  logic [mmu_pkg::VPN_W-1:0]      virtual_address,
    input  logic [mmu_pkg::PPN_W-1:0]      matp_ppn,
    output logic                           resolve_ack,
    output logic                           level,
    output logic [mmu_pkg::VPN_PART_W-1:0] vpn_lo,
    output logic                           walking,
    pte_fetch_if.engine                    fetch,
    walk_step_if.engine                    step
);

    logic                           read_issued;
    logic                           accept;
    logic                           descend;
    logic [mmu_pkg::PPN_W-1:0]      table_base;
    logic [mmu_pkg::VPN_W-1:0]      saved_vpn;
    logic [mmu_pkg::VPN_PART_W-1:0] vpn_hi;
    logic [mmu_pkg::VPN_PART_W-1:0] vpn_index;

    assign resolve_ack = !walking;
    assign accept      = resolve_request && resolve_ack;
    assign descend     = step.step_valid && (step.step == pte_pkg::step_descend);

    assign vpn_hi = saved_vpn[mmu_pkg::VPN1_MSB:mmu_pkg::VPN1_LSB];
    assign vpn_lo = saved_vpn[mmu_pkg::VPN0_MSB:mmu_pkg::VPN0_LSB];

    // pick the index of the level being walked
    assign vpn_index = (level == mmu_pkg::TOP_LEVEL) ? vpn_hi : vpn_lo;

    assign fetch.address = {table_base, vpn_index, {mmu_pkg::PTE_OFFSET_W{1'b0}}};
    assign fetch.read    = walking && !read_issued;

    // idle / walking state, level and issue tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            walking     <= 1'b0;
            read_issued <= 1'b0;
            level       <= mmu_pkg::TOP_LEVEL;
        end else if (!walking) begin
            read_issued <= 1'b0;
            level       <= mmu_pkg::TOP_LEVEL;
            if (accept) begin
                walking <= 1'b1;
            end
        end else begin
            if (fetch.read && !fetch.waitrequest) begin
                read_issued <= 1'b1;
            end
            if (descend) begin
                level       <= mmu_pkg::LEAF_LEVEL;
                read_issued <= 1'b0;
            end else if (step.step_valid) begin
                // leaf or fault ends the walk
                walking <= 1'b0;
            end
        end
    end

    // request and table base captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            saved_vpn  <= virtual_address;
            table_base <= matp_ppn;
        end else if (walking && descend) begin
            table_base <= step.next_table;
        end
    end

endmodule

// File: pte_decode.sv
`timescale 1ns/1ps

module pte_decode (
    pte_fetch_if.decode                    fetch,
    input  logic                           level,
    input  logic [mmu_pkg::VPN_PART_W-1:0] vpn_lo,
    input  logic                           walking,
    walk_step_if.decode                    step
);

    pte_pkg::pte_word_u  pte;
    pte_pkg::walk_step_e step_kind;

    logic accepted;
    logic pma_error;
    logic pte_invalid;
    logic pte_is_leaf;
    logic pte_is_pointer;
    logic pte_misaligned;

    assign pte = fetch.readdata;

    // response only counts while a walk is running
    assign accepted = walking && fetch.readdatavalid && !fetch.waitrequest;

    assign pma_error = (fetch.response != '0);

    assign pte_invalid = !pte.leaf.flags[pte_pkg::V_BIT] ||
                         (!pte.leaf.flags[pte_pkg::R_BIT] && pte.leaf.flags[pte_pkg::W_BIT]);

    assign pte_is_leaf = pte.leaf.flags[pte_pkg::R_BIT] || pte.leaf.flags[pte_pkg::X_BIT];

    assign pte_is_pointer = (pte.ptr.flags[3:0] == pte_pkg::PTR_CODE);

    // megapage must have its low ppn part clear
    assign pte_misaligned = (level == mmu_pkg::TOP_LEVEL) && (pte.leaf.ppn_lo != '0);

    always_comb begin
        if (pma_error) begin
            step_kind = pte_pkg::step_access_fault;
        end else if (pte_invalid) begin
            step_kind = pte_pkg::step_page_fault;
        end else if (pte_is_leaf) begin
            if (pte_misaligned) begin
                step_kind = pte_pkg::step_page_fault;
            end else begin
                step_kind = pte_pkg::step_leaf;
            end
        end else if (pte_is_pointer) begin
            // no table below level 0
            if (level == mmu_pkg::TOP_LEVEL) begin
                step_kind = pte_pkg::step_descend;
            end else begin
                step_kind = pte_pkg::step_page_fault;
            end
        end else begin
            step_kind = pte_pkg::step_page_fault;
        end
    end

    assign step.step_valid = accepted;
    assign step.step       = step_kind;

    // megapage keeps the level-0 index of the request
    assign step.phys_ppn = {pte.leaf.ppn_hi,
                            (level == mmu_pkg::TOP_LEVEL) ? vpn_lo : pte.leaf.ppn_lo};

    assign step.access_bits = pte.leaf.flags;
    assign step.next_table  = pte.ptr.next_table;

endmodule

// File: walk_step_if.sv
`timescale 1ns/1ps

interface walk_step_if;

    logic                          step_valid;
    pte_pkg::walk_step_e           step;
    logic [mmu_pkg::PPN_W-1:0]     phys_ppn;
    logic [pte_pkg::FLAGS_W-1:0]   access_bits;
    logic [mmu_pkg::PPN_W-1:0]     next_table;

    modport decode (
        output step_valid,
        output step,
        output phys_ppn,
        output access_bits,
        output next_table
    );

    modport engine (
        input step_valid,
        input step,
        input next_table
    );

    modport result (
        input step_valid,
        input step,
        input phys_ppn,
        input access_bits
    );

endinterface

// File: pte_fetch_if.sv
`timescale 1ns/1ps

interface pte_fetch_if;

    logic [mmu_pkg::MEM_ADDR_W-1:0] address;
    logic                           read;
    logic [pte_pkg::PTE_W-1:0]      readdata;
    logic                           readdatavalid;
    logic                           waitrequest;
    logic [pte_pkg::RESP_W-1:0]     response;

    // engine issues reads and holds them under waitrequest
    modport engine (
        output address,
        output read,
        input  waitrequest,
        input  readdatavalid
    );

    // decode looks at the returned word and its response
    modport decode (
        input readdata,
        input response,
        input readdatavalid,
        input waitrequest
    );

endinterface

// File: pte_pkg.sv
package pte_pkg;

    localparam int PTE_W = 32;

    // low byte of the entry holds the access bits
    localparam int FLAGS_W  = 8;
    localparam int RSW_W    = 2;
    localparam int PPN_LO_W = 10;
    localparam int PPN_HI_W = PTE_W - PPN_LO_W - RSW_W - FLAGS_W;

    localparam int V_BIT = 0;
    localparam int R_BIT = 1;
    localparam int W_BIT = 2;
    localparam int X_BIT = 3;

    // valid with r, w, x all clear marks a pointer to the next table
    localparam logic [3:0] PTR_CODE = 4'b0001;

    // bus response travels with every returned entry, zero is okay
    localparam int RESP_W = 2;

    typedef struct packed {
        logic [PPN_HI_W-1:0] ppn_hi;
        logic [PPN_LO_W-1:0] ppn_lo;
        logic [RSW_W-1:0]    rsw;
        logic [FLAGS_W-1:0]  flags;
    } pte_leaf_t;

    typedef struct packed {
        logic [mmu_pkg::PPN_W-1:0] next_table;
        logic [RSW_W-1:0]          rsw;
        logic [FLAGS_W-1:0]        flags;
    } pte_ptr_t;

    // one entry word, read as a leaf or as a pointer
    typedef union packed {
        pte_leaf_t leaf;
        pte_ptr_t  ptr;
    } pte_word_u;

    typedef enum logic [1:0] {
        step_descend      = 2'd0,
        step_leaf         = 2'd1,
        step_page_fault   = 2'd2,
        step_access_fault = 2'd3
    } walk_step_e;

endpackage

// File: mmu_pkg.sv
package mmu_pkg;

    // virtual page number, two levels of index
    localparam int VPN_W      = 20;
    localparam int VPN_PART_W = 10;
    localparam int LEVELS     = 2;

    // level-1 index sits in the upper half of the vpn
    localparam int VPN1_LSB = VPN_PART_W;
    localparam int VPN1_MSB = VPN_W - 1;
    localparam int VPN0_LSB = 0;
    localparam int VPN0_MSB = VPN_PART_W - 1;

    // physical page number, also used as a table base
    localparam int PPN_W = 22;

    // entries are 4 bytes wide, so the index is shifted by two
    localparam int PTE_OFFSET_W = 2;

    // byte address on the read port: base, index, entry offset
    localparam int MEM_ADDR_W = PPN_W + VPN_PART_W + PTE_OFFSET_W;

    // level encoding for the walk
    localparam logic TOP_LEVEL  = 1'b1;
    localparam logic LEAF_LEVEL = 1'b0;

endpackage
